// File: compile.f
source/mips_pkg.sv
source/dec_exe_if.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/mips_core.sv
tb/mips_core_props.sv
tb/mips_core_tb.sv

// File: tb/mips_core_testdata.txt
// inst     wb_valid wb_addr wb_data trap cause (hex, cause 1 overflow, 2 illegal)
// a wb_valid of e marks the end of the data
// immediate operations
24011234 1 01 00001234 0 0
3402f0f0 1 02 0000f0f0 0 0
3c038000 1 03 80000000 0 0
2404ffff 1 04 ffffffff 0 0
30850ff0 1 05 00000ff0 0 0
3846ffff 1 06 00000f0f 0 0
28870001 1 07 00000001 0 0
2828ffff 1 08 00000000 0 0
3c097fff 1 09 7fff0000 0 0
3529ffff 1 09 7fffffff 0 0
// register operations and shifts
00225020 1 0a 00010324 0 0
00415822 1 0b 0000debc 0 0
01296021 1 0c fffffffe 0 0
00016823 1 0d ffffedcc 0 0
00467024 1 0e 00000000 0 0
00467825 1 0f 0000ffff 0 0
00648026 1 10 7fffffff 0 0
00228827 1 11 ffff0d0b 0 0
0061902a 1 12 00000001 0 0
0061982b 1 13 00000000 0 0
0001a100 1 14 00012340 0 0
0003aa02 1 15 00800000 0 0
0003b203 1 16 ff800000 0 0
// dependent chain
24180005 1 18 00000005 0 0
0318c021 1 18 0000000a 0 0
27190001 1 19 0000000b 0 0
0319d023 1 1a ffffffff 0 0
031ad825 1 1b ffffffff 0 0
// overflow traps, then readers of the old values
01295020 0 00 00000000 1 1
00615822 0 00 00000000 1 1
212c0001 0 00 00000000 1 1
0180f021 1 1e fffffffe 0 0
0160e821 1 1d 0000debc 0 0
0140f821 1 1f 00010324 0 0
// illegal encodings
fc000000 0 00 00000000 1 2
0022503f 0 00 00000000 1 2
01400821 1 01 00010324 0 0
// register zero and nop
24200007 0 00 00000000 0 0
00000000 0 00 00000000 0 0
00001021 1 02 00000000 0 0
00000000 e 00 00000000 0 0

// File: tb/mips_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb;

    localparam int max_records = 64;
    localparam int fields      = 6;  // words per record in the data file
    localparam int drain_limit = 20;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        wb_valid;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        trap;
    logic [1:0]  trap_cause;

    logic [31:0] testdata [0:max_records*fields-1];

    // expected outcomes in flight with entry 3 due at the outputs
    logic        pipe_live     [0:3];
    logic        pipe_wb_valid [0:3];
    logic [4:0]  pipe_wb_addr  [0:3];
    logic [31:0] pipe_wb_data  [0:3];
    logic        pipe_trap     [0:3];
    logic [1:0]  pipe_cause    [0:3];

    integer seed = 32'h9bac_7150;
    int     errors;
    int     checks;
    int     records;
    int     drain_cycles;

    always #5 clk = ~clk;

    mips_core i_mips_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .trap       (trap),
        .trap_cause (trap_cause)
    );

    ////////////////////////////////////////
    // checking
    ////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic check_outputs();
        checks++;
        assert (wb_valid === pipe_wb_valid[3])
            else report_mismatch("wb_valid", pipe_wb_valid[3], wb_valid);
        if (pipe_wb_valid[3])
        begin
            assert (wb_addr === pipe_wb_addr[3])
                else report_mismatch("wb_addr", pipe_wb_addr[3], wb_addr);
            assert (wb_data === pipe_wb_data[3])
                else report_mismatch("wb_data", pipe_wb_data[3], wb_data);
        end
        assert (trap === pipe_trap[3])
            else report_mismatch("trap", pipe_trap[3], trap);
        assert (trap_cause === pipe_cause[3])
            else report_mismatch("trap_cause", pipe_cause[3], trap_cause);
    endtask

    // entry 3 was checked already
    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < 3; i++)
            n += pipe_live[i];
        return n;
    endfunction

    function automatic logic record_present(input int r);
        return testdata[r*fields+1] === 32'h0 || testdata[r*fields+1] === 32'h1;
    endfunction

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic run_cycle(input logic valid, input logic [31:0] word, input logic live,
                             input logic exp_wb_valid, input logic [4:0] exp_wb_addr,
                             input logic [31:0] exp_wb_data, input logic exp_trap,
                             input logic [1:0] exp_cause);
        @(posedge clk);
        inst_valid <= valid;
        inst       <= word;
        for (int i = 3; i > 0; i--)
        begin
            pipe_live[i]     = pipe_live[i-1];
            pipe_wb_valid[i] = pipe_wb_valid[i-1];
            pipe_wb_addr[i]  = pipe_wb_addr[i-1];
            pipe_wb_data[i]  = pipe_wb_data[i-1];
            pipe_trap[i]     = pipe_trap[i-1];
            pipe_cause[i]    = pipe_cause[i-1];
        end
        pipe_live[0]     = live;
        pipe_wb_valid[0] = exp_wb_valid;
        pipe_wb_addr[0]  = exp_wb_addr;
        pipe_wb_data[0]  = exp_wb_data;
        pipe_trap[0]     = exp_trap;
        pipe_cause[0]    = exp_cause;
        @(negedge clk);  // outputs settled
        check_outputs();
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, $random(seed), 1'b0, 1'b0, 5'd0, 32'd0, 1'b0, 2'd0);
    endtask

    task automatic record_cycle(input int r);
        run_cycle(1'b1, testdata[r*fields], 1'b1, testdata[r*fields+1][0],
                  testdata[r*fields+2][4:0], testdata[r*fields+3],
                  testdata[r*fields+4][0], testdata[r*fields+5][1:0]);
    endtask

    initial
    begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        errors     = 0;
        checks     = 0;
        records    = 0;
        for (int i = 0; i < 4; i++)
        begin
            pipe_live[i]     = 1'b0;
            pipe_wb_valid[i] = 1'b0;
            pipe_wb_addr[i]  = '0;
            pipe_wb_data[i]  = '0;
            pipe_trap[i]     = 1'b0;
            pipe_cause[i]    = '0;
        end
        $readmemh("tb/mips_core_testdata.txt", testdata);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        while (records < max_records && record_present(records))
        begin
            if (records > 0 && ($random(seed) & 7) == 0)
                idle_cycle();  // bubble between instructions
            record_cycle(records);
            records++;
        end
        if (records == 0)
        begin
            errors++;
            $display("no records were read from tb/mips_core_testdata.txt");
        end

        drain_cycles = 0;
        while (pending_count() != 0 && drain_cycles < drain_limit)
        begin
            idle_cycle();
            drain_cycles++;
        end
        if (pending_count() != 0)
        begin
            errors++;
            $display("timeout: results still outstanding after %0d idle cycles", drain_limit);
        end

        errors += i_mips_core.i_mips_core_props.failures;

        $display("records: %0d, checks: %0d, errors: %0d", records, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/mips_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_props
    import mips_pkg::*;
(
    input wire       clk,
    input wire       rst_n,
    input wire       wb_valid,
    input wire [4:0] wb_addr,
    input wire       trap,
    input wire [1:0] trap_cause
);

    int failures = 0;

    wb_trap_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_valid && trap))
        else
        begin
            failures++;
            $error("wb_valid and trap high in the same cycle");
        end

    wb_addr_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_addr != '0)
        else
        begin
            failures++;
            $error("writeback reported for register zero");
        end

    // cause is none exactly when no trap
    cause_matches_trap: assert property (@(posedge clk) disable iff (!rst_n)
        (trap_cause == cause_none) == !trap)
        else
        begin
            failures++;
            $error("trap_cause does not agree with trap");
        end

    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_valid && !trap)
        else
        begin
            failures++;
            $error("output active in the cycle after reset release");
        end

endmodule

bind mips_core mips_core_props i_mips_core_props (.*);

`default_nettype wire

// File: source/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core
    import mips_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      inst_valid,
    input  wire [data_width-1:0]     inst,
    output logic                     wb_valid,
    output logic [reg_addr_width-1:0] wb_addr,
    output logic [data_width-1:0]    wb_data,
    output logic                     trap,
    output logic [1:0]               trap_cause
);

    reg_addr_t   rs_addr;
    reg_addr_t   rt_addr;
    word_t       rs_data;
    word_t       rt_data;

    // execute -> result, execute -> decode forwarding
    logic        exe_valid;
    logic        exe_wr_en;
    reg_addr_t   exe_dest;
    word_t       exe_result;
    trap_cause_e exe_cause;

    dec_exe_if dec_exe ();

    register_file i_register_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wb_valid),
        .wr_addr (wb_addr),
        .wr_data (wb_data)
    );

    decode_stage i_decode_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .exe_valid  (exe_valid),
        .exe_wr_en  (exe_wr_en),
        .exe_dest   (exe_dest),
        .exe_result (exe_result),
        .wb_valid   (wb_valid),   // result stage doubles as forward source
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .dec        (dec_exe.decode)
    );

    execute_stage i_execute_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec        (dec_exe.execute),
        .exe_valid  (exe_valid),
        .exe_wr_en  (exe_wr_en),
        .exe_dest   (exe_dest),
        .exe_result (exe_result),
        .exe_cause  (exe_cause)
    );

    result_stage i_result_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .exe_valid  (exe_valid),
        .exe_wr_en  (exe_wr_en),
        .exe_dest   (exe_dest),
        .exe_result (exe_result),
        .exe_cause  (exe_cause),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .trap       (trap),
        .trap_cause (trap_cause)
    );

endmodule

`default_nettype wire

// File: source/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage
    import mips_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         exe_valid,
    input  wire         exe_wr_en,
    input  reg_addr_t   exe_dest,
    input  word_t       exe_result,
    input  trap_cause_e exe_cause,
    output logic        wb_valid,
    output reg_addr_t   wb_addr,
    output word_t       wb_data,
    output logic        trap,
    output trap_cause_e trap_cause
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_valid   <= 1'b0;
            trap       <= 1'b0;
            trap_cause <= cause_none;
        end
        else
        begin
            // writes to $zero vanish here
            wb_valid   <= exe_valid && exe_wr_en && exe_dest != '0;
            trap       <= exe_valid && exe_cause != cause_none;
            trap_cause <= exe_valid ? exe_cause : cause_none;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_addr <= exe_dest;
        wb_data <= exe_result;
    end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import mips_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    dec_exe_if.execute  dec,
    output logic        exe_valid,
    output logic        exe_wr_en,
    output reg_addr_t   exe_dest,
    output word_t       exe_result,
    output trap_cause_e exe_cause
);

    localparam int msb = data_width - 1;

    word_t       a;
    word_t       b;
    word_t       alu_res;
    logic        add_ovf;
    logic        sub_ovf;
    logic        ovf;
    trap_cause_e cause;

    assign a = dec.src_a;
    assign b = dec.src_b;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb
    begin
        case (dec.alu_op)
            alu_add:  alu_res = a + b;
            alu_sub:  alu_res = a - b;
            alu_and:  alu_res = a & b;
            alu_or:   alu_res = a | b;
            alu_xor:  alu_res = a ^ b;
            alu_nor:  alu_res = ~(a | b);
            alu_slt:  alu_res = {{msb{1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: alu_res = {{msb{1'b0}}, a < b};
            alu_sll:  alu_res = b << dec.shamt;
            alu_srl:  alu_res = b >> dec.shamt;
            alu_sra:  alu_res = $signed(b) >>> dec.shamt; // sign fill
            alu_lui:  alu_res = {b[15:0], 16'h0000};
            default:  alu_res = '0;
        endcase
    end

    // signed overflow, operands alike in sign and result flipped
    assign add_ovf = (a[msb] == b[msb]) && (alu_res[msb] != a[msb]);
    assign sub_ovf = (a[msb] != b[msb]) && (alu_res[msb] != a[msb]);
    assign ovf     = dec.ovf_check &&
                     ((dec.alu_op == alu_add && add_ovf) || (dec.alu_op == alu_sub && sub_ovf));

    always_comb
    begin
        if (dec.illegal)
            cause = cause_illegal;
        else if (ovf)
            cause = cause_overflow;
        else
            cause = cause_none;
    end

    ////////////////////////////////////////
    // pipeline register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            exe_valid <= 1'b0;
            exe_wr_en <= 1'b0;
            exe_cause <= cause_none;
        end
        else
        begin
            exe_valid <= dec.valid;
            exe_wr_en <= dec.valid && dec.wr_en && cause == cause_none; // traps never write
            exe_cause <= dec.valid ? cause : cause_none;
        end
    end

    always_ff @(posedge clk)
    begin
        exe_dest   <= dec.dest;
        exe_result <= alu_res;
    end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import mips_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        inst_valid,
    input  word_t      inst,
    output reg_addr_t  rs_addr,
    output reg_addr_t  rt_addr,
    input  word_t      rs_data,
    input  word_t      rt_data,
    input  wire        exe_valid,
    input  wire        exe_wr_en,
    input  reg_addr_t  exe_dest,
    input  word_t      exe_result,
    input  wire        wb_valid,
    input  reg_addr_t  wb_addr,
    input  word_t      wb_data,
    dec_exe_if.decode  dec
);

    logic        inst_valid_q;
    word_t       inst_q;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rd;
    logic [15:0] imm;
    alu_op_e     alu_op;
    logic        illegal;
    logic        use_imm;
    logic        sign_ext;
    logic        ovf_check;
    word_t       imm_ext;
    word_t       rs_fwd;
    word_t       rt_fwd;

    ////////////////////////////////////////
    // pipeline register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            inst_valid_q <= 1'b0;
        else
            inst_valid_q <= inst_valid;
    end

    always_ff @(posedge clk)
    begin
        inst_q <= inst;
    end

    ////////////////////////////////////////
    // field decode
    ////////////////////////////////////////

    assign opcode  = inst_q[31:26];
    assign rs_addr = inst_q[25:21];
    assign rt_addr = inst_q[20:16];
    assign rd      = inst_q[15:11];
    assign funct   = inst_q[5:0];
    assign imm     = inst_q[15:0];

    always_comb
    begin
        alu_op  = alu_add;
        illegal = 1'b0;
        case (opcode)
            op_special:
            begin
                case (funct)
                    fn_add, fn_addu: alu_op = alu_add;
                    fn_sub, fn_subu: alu_op = alu_sub;
                    fn_and:          alu_op = alu_and;
                    fn_or:           alu_op = alu_or;
                    fn_xor:          alu_op = alu_xor;
                    fn_nor:          alu_op = alu_nor;
                    fn_slt:          alu_op = alu_slt;
                    fn_sltu:         alu_op = alu_sltu;
                    fn_sll:          alu_op = alu_sll;
                    fn_srl:          alu_op = alu_srl;
                    fn_sra:          alu_op = alu_sra;
                    default:         illegal = 1'b1;
                endcase
            end
            op_addi, op_addiu: alu_op = alu_add;
            op_slti:           alu_op = alu_slt;
            op_andi:           alu_op = alu_and;
            op_ori:            alu_op = alu_or;
            op_xori:           alu_op = alu_xor;
            op_lui:            alu_op = alu_lui;
            default:           illegal = 1'b1;
        endcase
    end

    assign use_imm   = (opcode != op_special);
    assign sign_ext  = (opcode == op_addi) || (opcode == op_addiu) || (opcode == op_slti);
    assign ovf_check = (opcode == op_addi) ||
                       (opcode == op_special && (funct == fn_add || funct == fn_sub));
    assign imm_ext   = sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    ////////////////////////////////////////
    // forwarding, newest first
    ////////////////////////////////////////

    assign rs_fwd = (rs_addr != '0 && exe_valid && exe_wr_en && exe_dest == rs_addr) ? exe_result :
                    (rs_addr != '0 && wb_valid && wb_addr == rs_addr) ? wb_data : rs_data;
    assign rt_fwd = (rt_addr != '0 && exe_valid && exe_wr_en && exe_dest == rt_addr) ? exe_result :
                    (rt_addr != '0 && wb_valid && wb_addr == rt_addr) ? wb_data : rt_data;

    assign dec.valid     = inst_valid_q;
    assign dec.alu_op    = alu_op;
    assign dec.src_a     = rs_fwd;
    assign dec.src_b     = use_imm ? imm_ext : rt_fwd;
    assign dec.shamt     = inst_q[10:6];
    assign dec.dest      = use_imm ? rt_addr : rd; // rt for I-type
    assign dec.wr_en     = !illegal;
    assign dec.ovf_check = ovf_check;
    assign dec.illegal   = illegal;

endmodule

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
    import mips_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rs_data,
    output word_t     rt_data,
    input  wire       wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [1:2**reg_addr_width-1]; // $zero is not stored

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < 2**reg_addr_width; i++)
                regs[i] <= '0;
        end
        else if (wr_en && wr_addr != '0)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // no write bypass here, decode forwards from result
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// File: source/dec_exe_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded instruction, decode -> execute
interface dec_exe_if
    import mips_pkg::*;
();

    logic      valid;
    alu_op_e   alu_op;
    word_t     src_a;
    word_t     src_b;     // rt or immediate
    logic [4:0] shamt;
    reg_addr_t dest;
    logic      wr_en;
    logic      ovf_check; // add, sub, addi
    logic      illegal;

    modport decode (output valid, alu_op, src_a, src_b, shamt, dest, wr_en, ovf_check, illegal);
    modport execute (input valid, alu_op, src_a, src_b, shamt, dest, wr_en, ovf_check, illegal);

endinterface

`default_nettype wire

// File: source/mips_pkg.sv
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;

    typedef logic [data_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // major opcodes, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00, // R-type, see funct
        op_addi    = 6'h08,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f
    } opcode_e;

    // function codes, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_add  = 6'h20,
        fn_addu = 6'h21,
        fn_sub  = 6'h22,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        cause_none     = 2'd0,
        cause_overflow = 2'd1,
        cause_illegal  = 2'd2
    } trap_cause_e;

endpackage

`default_nettype wire
